/* bench/exEx1Tests.svh */
`ifndef EXEX1TESTS_SVH
`define EXEX1TESTS_SVH

	function automatic logic condEnabled(input logic [1:0] cc, input logic srT);
		case (cc)
			exPkg::ccAl: return 1'b1;
			exPkg::ccCt: return srT;
			exPkg::ccCf: return !srT;
			default:     return 1'b0;	// NV
		endcase
	endfunction

	// Base plus index scaled by access size, wraps at 32 bits
	function automatic logic [31:0] effAddr(input logic [63:0] base, input logic [63:0] index,
			input logic [1:0] size);
		return base[31:0] + (index[31:0] << size);
	endfunction

	function automatic logic [7:0] memIxt(input logic [1:0] size, input logic sign,
			input logic [1:0] srcSel);
		return {2'b00, size, 1'b0, sign, srcSel};
	endfunction

	// SP moves by one quadword inside bits 27..3
	function automatic logic [63:0] stepSp(input logic [63:0] sp, input logic up);
		logic [24:0] field;
		logic [63:0] res;
		field = sp[27:3];
		field = up ? field + 25'd1 : field - 25'd1;
		res = sp;
		res[27:3] = field;
		return res;
	endfunction

	task automatic checkRedirect(input string name, input logic taken, input logic [31:0] target);
		if (taken) begin
			checkValue({name, " regIdCn1"}, 64'(exPkg::crPc), 64'(regIdCn1));
			checkValue({name, " regValCn1"}, 64'(target), regValCn1);
		end else begin
			checkValue({name, " regIdCn1"}, 64'(exPkg::crZzr), 64'(regIdCn1));
		end
	endtask

	task automatic resetValueTest();
		checkValue("reset regIdRn1", 64'(exPkg::grZzr), 64'(regIdRn1));
		checkValue("reset regIdCn1", 64'(exPkg::crZzr), 64'(regIdCn1));
		checkValue("reset memOpm", 64'(exPkg::opmReady), 64'(memOpm));
		checkValue("reset regOutSp", 64'd0, regOutSp);
		checkValue("reset exTrapExc", 64'd0, 64'(exTrapExc));
	endtask

	task automatic predicationTest();
		logic [63:0] r;
		logic [1:0]  cc;
		logic        en;
		for (int i = 0; i < 8; i++) begin
			r = rand64();
			cc = 2'(i);
			regInSr  = rand64();	// Random SR.T
			regValRs = rand64();
			regValRt = rand64();
			regIdRm  = r[5:0];
			en = condEnabled(cc, regInSr[0]);
			issueOp(cc, exPkg::ucLeaMr, memIxt(r[9:8], 1'b0, 2'd0));
			checkValue("pred regIdRn1", en ? 64'(regIdRm) : 64'(exPkg::grZzr), 64'(regIdRn1));
			if (en) begin
				checkValue("pred regValRn1", 64'(effAddr(regValRs, regValRt, r[9:8])), regValRn1);
			end
		end
		opBraFlush = 1'b1;
		regIdRm = {1'b0, r[4:0]};	// Anything but the null GPR
		issueOp(exPkg::ccAl, exPkg::ucLeaMr, 8'h00);
		checkValue("flush lea regIdRn1", 64'(exPkg::grZzr), 64'(regIdRn1));
		issueOp(exPkg::ccAl, exPkg::ucJmp, 8'h00);
		checkValue("flush jmp regIdCn1", 64'(exPkg::crZzr), 64'(regIdCn1));
		issueOp(exPkg::ccAl, exPkg::ucMovRm, 8'h00);
		checkValue("flush store memOpm", 64'(exPkg::opmReady), 64'(memOpm));
		opBraFlush = 1'b0;
		r = rand64();
		opPreBra = 1'b1;
		regValPc = r[31:0];
		issueOp(exPkg::ccNv, exPkg::ucBra, 8'h00);	// Predicted taken, resolves not taken
		checkRedirect("bra nb", 1'b1, regValPc);
		opPreBra = 1'b0;
	endtask

	task automatic loadStoreTest();
		logic [63:0] r;
		logic [1:0]  size;
		logic        sign;
		logic [31:0] addr;
		for (int i = 0; i < 8; i++) begin
			r = rand64();
			size = 2'(i);
			sign = r[0];
			regValRs = rand64();
			regValRt = rand64();
			regValRm = rand64();
			regIdRm  = r[13:8];
			addr     = effAddr(regValRs, regValRt, size);
			issueOp(exPkg::ccAl, exPkg::ucMovRm, memIxt(size, sign, 2'd0));
			checkValue("store memAddr", 64'(addr), 64'(memAddr));
			checkValue("store memOpm", 64'({2'b10, sign, size}), 64'(memOpm));
			checkValue("store memDataOut", regValRm, memDataOut);
			issueOp(exPkg::ccAl, exPkg::ucMovMr, memIxt(size, sign, 2'd0));
			checkValue("load memAddr", 64'(addr), 64'(memAddr));
			checkValue("load memOpm", 64'({2'b01, sign, size}), 64'(memOpm));
			checkValue("load heldIdRn1", 64'(regIdRm), 64'(heldIdRn1));
		end
	endtask

	task automatic pushPopTest();
		logic [63:0] r;
		logic [63:0] expSp;
		logic [63:0] expData;
		for (int sel = 0; sel < 4; sel++) begin
			r = rand64();
			regInSp   = rand64();
			regValRs  = rand64();
			regValCRm = rand64();
			regInSchm = r[7:0];
			expSp = stepSp(regInSp, 1'b0);
			case (sel)
				1:       expData = regValCRm;
				2:       expData = 64'd0;	// FPR source absent
				default: expData = regValRs;
			endcase
			issueOp(exPkg::ccAl, exPkg::ucPushx, memIxt(2'd3, 1'b0, 2'(sel)));
			checkValue("push regOutSp", expSp, regOutSp);
			checkValue("push memAddr", 64'(expSp[31:0]), 64'(memAddr));	// Pre-decrement
			checkValue("push memOpm", 64'(exPkg::opmWrQ), 64'(memOpm));
			checkValue("push memDataOut", expData, memDataOut);
			checkValue("push regOutSchm", 64'(regInSchm | (8'd1 << exPkg::schmSp)),
				64'(regOutSchm));
			checkValue("push heldIdCn1", 64'(exPkg::grImm), 64'(heldIdCn1));
		end
		for (int k = 0; k < 2; k++) begin
			r = rand64();
			regInSp   = rand64();
			regInSchm = r[7:0];
			if (k == 1) begin
				regInSp[27:3] = '1;	// Carry must stop at bit 27
			end
			issueOp(exPkg::ccAl, exPkg::ucPopx, memIxt(2'd3, 1'b0, 2'd0));
			checkValue("pop regOutSp", stepSp(regInSp, 1'b1), regOutSp);
			checkValue("pop memAddr", 64'(regInSp[31:0]), 64'(memAddr));
			checkValue("pop memOpm", 64'(exPkg::opmRdQ), 64'(memOpm));
			checkValue("pop regOutSchm", 64'(regInSchm | (8'd1 << exPkg::schmSp)),
				64'(regOutSchm));
			checkValue("pop heldIdCn1", 64'(exPkg::grImm), 64'(heldIdCn1));
		end
	endtask

	task automatic branchTest();
		logic [63:0] r;
		logic [31:0] target;
		for (int p = 0; p < 2; p++) begin
			r = rand64();
			opPreBra = p[0];
			regValRs = rand64();
			regValRt = rand64();
			regValPc = r[31:0];
			regInLr  = r[63:32];
			target   = effAddr(regValRs, regValRt, r[1:0]);
			issueOp(exPkg::ccAl, exPkg::ucBra, memIxt(r[1:0], 1'b0, 2'd0));
			checkRedirect("bra", !opPreBra, target);
			checkValue("bra regOutLr", 64'(regInLr), 64'(regOutLr));
			issueOp(exPkg::ccAl, exPkg::ucBsr, memIxt(r[1:0], 1'b0, 2'd0));
			checkRedirect("bsr", !opPreBra, target);
			checkValue("bsr regOutLr", 64'(regValPc), 64'(regOutLr));
			issueOp(exPkg::ccAl, exPkg::ucJmp, 8'h00);
			checkRedirect("jmp", 1'b1, regValRs[31:0]);
			checkValue("jmp regOutLr", 64'(regInLr), 64'(regOutLr));
			issueOp(exPkg::ccAl, exPkg::ucJsr, 8'h00);
			checkRedirect("jsr", 1'b1, regValRs[31:0]);
			checkValue("jsr regOutLr", 64'(regValPc), 64'(regOutLr));
		end
		opPreBra = 1'b0;
	endtask

	task automatic moveTest();
		logic [63:0] r;
		logic [63:0] expVal;
		logic [1:0]  sel;
		for (int i = 0; i < 8; i++) begin
			r = rand64();
			sel = 2'(i);
			regValRs  = rand64();
			regValImm = {r[40], r[31:0]};
			regIdRm   = r[46:41];
			issueOp(exPkg::ccAl, exPkg::ucMovIr, memIxt(2'd0, 1'b0, sel));
			case (sel)
				2'd0:    expVal = {{31{regValImm[32]}}, regValImm};	// Sign from bit 32
				2'd1:    expVal = (regValRs << 8) | 64'(regValImm[7:0]);
				2'd2:    expVal = (regValRs << 16) | 64'(regValImm[15:0]);
				default: expVal = (regValRs << 32) | 64'(regValImm[31:0]);
			endcase
			checkValue("movir regIdRn1", 64'(regIdRm), 64'(regIdRn1));
			checkValue("movir regValRn1", expVal, regValRn1);
		end
		r = rand64();
		regIdRm   = r[5:0];
		regValRs  = rand64();
		regValCRm = rand64();
		issueOp(exPkg::ccAl, exPkg::ucMovRc, 8'h00);
		checkValue("movrc regIdCn1", 64'(regIdRm[4:0]), 64'(regIdCn1));
		checkValue("movrc regValCn1", regValRs, regValCn1);
		checkValue("movrc regIdRn1", 64'(exPkg::grZzr), 64'(regIdRn1));
		issueOp(exPkg::ccAl, exPkg::ucMovCr, 8'h00);
		checkValue("movcr regIdRn1", 64'(regIdRm), 64'(regIdRn1));
		checkValue("movcr regValRn1", regValCRm, regValRn1);
	endtask

	task automatic flagTrapHoldTest();
		logic [63:0] r;
		logic [63:0] expSr;
		logic [5:0]  subOp;
		int          flagBit;
		for (int i = 0; i < 6; i++) begin
			regInSr = rand64();
			expSr   = regInSr;
			flagBit = i / 3;	// T first, then S
			case (i)
				0:       subOp = exPkg::ixClrt;
				1:       subOp = exPkg::ixSett;
				2:       subOp = exPkg::ixNott;
				3:       subOp = exPkg::ixClrs;
				4:       subOp = exPkg::ixSets;
				default: subOp = exPkg::ixNots;
			endcase
			case (i % 3)
				0:       expSr[flagBit] = 1'b0;
				1:       expSr[flagBit] = 1'b1;
				default: expSr[flagBit] = !regInSr[flagBit];
			endcase
			issueOp(exPkg::ccAl, exPkg::ucOpIxt, {2'b00, subOp});
			checkValue("flag regOutSr", expSr, regOutSr);
			checkValue("flag exHold", 64'd0, 64'(exHold));
		end
		r = rand64();
		regIdRm  = r[5:0];
		regInDlr = rand64();
		issueOp(exPkg::ccAl, exPkg::ucOpIxt, {2'b00, exPkg::ixTrapa});
		checkValue("trapa code", 64'({exPkg::trapaBase, regIdRm[3:0]}), 64'(exTrapExc));
		issueOp(exPkg::ccAl, exPkg::ucOpIxt, {2'b00, exPkg::ixSyse});
		checkValue("syse code", 64'({exPkg::syseBase, regInDlr[11:0]}), 64'(exTrapExc));
		issueOp(exPkg::ccAl, exPkg::ucOpIxt, {2'b00, exPkg::ixRte});
		checkValue("rte code", 64'(exPkg::trapRte), 64'(exTrapExc));
		// Hold is combinational, inputs are still applied here
		issueOp(exPkg::ccAl, exPkg::ucInvop, 8'h00);
		checkValue("invop exHold", 64'd1, 64'(exHold));
		issueOp(exPkg::ccAl, exPkg::ucOpIxt, {2'b00, exPkg::ixBreak});
		checkValue("break exHold", 64'd1, 64'(exHold));
		issueOp(exPkg::ccAl, 6'h2A, 8'h00);
		checkValue("unknown exHold", 64'd1, 64'(exHold));
		issueOp(exPkg::ccAl, exPkg::ucLeaMr, 8'h00);
		checkValue("valid exHold", 64'd0, 64'(exHold));
	endtask

`endif

/* bench/exEx1Tb.sv */
`timescale 1ns/1ps

module exEx1Tb;

	localparam int halfPeriod  = 20;
	localparam int resetCycles = 8;
	localparam int opBudget    = 100;	// Ops issued by all tests, rounded up
	localparam int cyclesPerOp = 20;	// One cycle each, the rest is slack
	localparam int watchdogCycles = resetCycles + opBudget * cyclesPerOp;

	logic                     clock;
	logic                     arstN;
	logic [7:0]               opUCmd;
	logic [7:0]               opUIxt;
	logic                     opBraFlush;
	logic                     opPreBra;
	logic [exPkg::gprIdW-1:0] regIdRm;
	logic [exPkg::dataW-1:0]  regValRs, regValRt, regValRm, regValCRm;
	logic [exPkg::addrW-1:0]  regValPc;
	logic [exPkg::immW-1:0]   regValImm;
	logic [exPkg::dataW-1:0]  regInSp, regInDlr, regInSr;
	logic [exPkg::addrW-1:0]  regInLr;
	logic [exPkg::schmW-1:0]  regInSchm;

	logic                     exHold;
	logic [exPkg::gprIdW-1:0] regIdRn1, heldIdRn1;
	logic [exPkg::dataW-1:0]  regValRn1, regValCn1;
	logic [exPkg::crIdW-1:0]  regIdCn1, heldIdCn1;
	logic [exPkg::dataW-1:0]  regOutSp, regOutSr, memDataOut;
	logic [exPkg::addrW-1:0]  regOutLr, memAddr;
	logic [exPkg::schmW-1:0]  regOutSchm;
	logic [exPkg::opmW-1:0]   memOpm;
	logic [exPkg::trapW-1:0]  exTrapExc;

	exEx1 exEx1_i (.*);

	always #(halfPeriod) clock = !clock;

	// Stops the run at the first difference
	task automatic checkValue(input string testName, input logic [63:0] expected,
			input logic [63:0] actual);
		if (actual !== expected) begin
			$display("MISMATCH %s expected %h actual %h", testName, expected, actual);
			$display("Some tests failed");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	function automatic logic [63:0] rand64();
		return {$urandom(), $urandom()};
	endfunction

	task automatic setIdle();
		opUCmd     = {exPkg::ccAl, exPkg::ucNop};
		opUIxt     = 8'h00;
		opBraFlush = 1'b0;
		opPreBra   = 1'b0;
		regIdRm    = '0;
		regValRs   = '0;
		regValRt   = '0;
		regValRm   = '0;
		regValCRm  = '0;
		regValPc   = '0;
		regValImm  = '0;
		regInSp    = '0;
		regInDlr   = '0;
		regInLr    = '0;
		regInSr    = '0;
		regInSchm  = '0;
	endtask

	// Caller is on a falling edge, returns on the next one with outputs settled
	task automatic issueOp(input logic [1:0] cc, input logic [5:0] uc, input logic [7:0] ixt);
		opUCmd = {cc, uc};
		opUIxt = ixt;
		@(posedge clock);	// Op latched here
		@(negedge clock);
	endtask

	`include "exEx1Tests.svh"

	// Watchdog
	initial begin
		repeat (watchdogCycles) @(posedge clock);
		$display("Watchdog expired, tests did not finish within %0d cycles", watchdogCycles);
		$display("Some tests failed");
		$fatal(1, "Timeout");
	end

	initial begin
		clock = 1'b0;
		arstN = 1'b0;
		setIdle();
		void'($urandom(32'hff870327));
		repeat (resetCycles) @(posedge clock);
		@(negedge clock);
		resetValueTest();
		arstN = 1'b1;
		predicationTest();
		loadStoreTest();
		pushPopTest();
		branchTest();
		moveTest();
		flagTrapHoldTest();
		$display("All tests passed");
		$finish;
	end

endmodule

/* exEx1.f */
+incdir+bench
verilog/exPkg.sv
verilog/exPredicate.sv
verilog/exAgu.sv
verilog/exUcmdDecode.sv
verilog/exStageLatch.sv
verilog/exEx1.sv
bench/exEx1Tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the exEx1 testbench with Verilator

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --top-module exEx1Tb -f exEx1.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/VexEx1Tb > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -qx "All tests passed" "$logFile"; then
	exit 0
fi
echo "Pass message not found in $logFile"
exit 1

/* verilog/exAgu.sv */
`timescale 1ns/1ps

module exAgu (
	input  logic [exPkg::addrW-1:0] base,
	input  logic [exPkg::addrW-1:0] index,
	input  exPkg::ixtWord_t         ixt,
	output logic [exPkg::addrW-1:0] aguAddr
);

	logic [exPkg::addrW-1:0] scaledIndex;

	// Index scaled by access size
	always_comb begin
		case (ixt.mem.size)
			2'd0:    scaledIndex = index;
			2'd1:    scaledIndex = {index[exPkg::addrW-2:0], 1'b0};
			2'd2:    scaledIndex = {index[exPkg::addrW-3:0], 2'b00};
			default: scaledIndex = {index[exPkg::addrW-4:0], 3'b000};
		endcase
	end

	assign aguAddr = base + scaledIndex;	// Wraps at 32 bits

endmodule

/* verilog/exEx1.sv */
`timescale 1ns/1ps

module exEx1 (
	input  logic                     clock,
	input  logic                     arstN,
	input  logic [7:0]               opUCmd,
	input  logic [7:0]               opUIxt,
	input  logic                     opBraFlush,
	input  logic                     opPreBra,
	input  logic [exPkg::gprIdW-1:0] regIdRm,
	input  logic [exPkg::dataW-1:0]  regValRs,	// Base
	input  logic [exPkg::dataW-1:0]  regValRt,	// Index
	input  logic [exPkg::dataW-1:0]  regValRm,	// Store data
	input  logic [exPkg::dataW-1:0]  regValCRm,
	input  logic [exPkg::addrW-1:0]  regValPc,
	input  logic [exPkg::immW-1:0]   regValImm,
	input  logic [exPkg::dataW-1:0]  regInSp,
	input  logic [exPkg::dataW-1:0]  regInDlr,
	input  logic [exPkg::addrW-1:0]  regInLr,
	input  logic [exPkg::dataW-1:0]  regInSr,
	input  logic [exPkg::schmW-1:0]  regInSchm,
	output logic                     exHold,
	output logic [exPkg::gprIdW-1:0] regIdRn1,
	output logic [exPkg::dataW-1:0]  regValRn1,
	output logic [exPkg::crIdW-1:0]  regIdCn1,
	output logic [exPkg::dataW-1:0]  regValCn1,
	output logic [exPkg::gprIdW-1:0] heldIdRn1,
	output logic [exPkg::crIdW-1:0]  heldIdCn1,
	output logic [exPkg::dataW-1:0]  regOutSp,
	output logic [exPkg::addrW-1:0]  regOutLr,
	output logic [exPkg::dataW-1:0]  regOutSr,
	output logic [exPkg::schmW-1:0]  regOutSchm,
	output logic [exPkg::addrW-1:0]  memAddr,
	output logic [exPkg::opmW-1:0]   memOpm,
	output logic [exPkg::dataW-1:0]  memDataOut,
	output logic [exPkg::trapW-1:0]  exTrapExc
);

	logic [exPkg::ucW-1:0]    ucEff;
	logic [exPkg::addrW-1:0]  aguAddr;
	logic [exPkg::gprIdW-1:0] nIdRn1;
	logic [exPkg::dataW-1:0]  nValRn1;
	logic [exPkg::crIdW-1:0]  nIdCn1;
	logic [exPkg::dataW-1:0]  nValCn1;
	logic [exPkg::gprIdW-1:0] nHeldIdRn1;
	logic [exPkg::crIdW-1:0]  nHeldIdCn1;
	logic [exPkg::dataW-1:0]  nOutSp;
	logic [exPkg::addrW-1:0]  nOutLr;
	logic [exPkg::dataW-1:0]  nOutSr;
	logic [exPkg::schmW-1:0]  nOutSchm;
	logic [exPkg::addrW-1:0]  nMemAddr;
	logic [exPkg::opmW-1:0]   nMemOpm;
	logic [exPkg::dataW-1:0]  nMemDataOut;
	logic [exPkg::trapW-1:0]  nTrapExc;

	exPredicate exPredicate_i (
		.opUCmd     (opUCmd),
		.opBraFlush (opBraFlush),
		.srT        (regInSr[0]),	// SR.T
		.ucEff      (ucEff)
	);

	exAgu exAgu_i (
		.base    (regValRs[exPkg::addrW-1:0]),
		.index   (regValRt[exPkg::addrW-1:0]),
		.ixt     (opUIxt),
		.aguAddr (aguAddr)
	);

	exUcmdDecode exUcmdDecode_i (
		.ucEff       (ucEff),
		.ixt         (opUIxt),
		.opPreBra    (opPreBra),
		.aguAddr     (aguAddr),
		.regIdRm     (regIdRm),
		.regValRs    (regValRs),
		.regValRm    (regValRm),
		.regValCRm   (regValCRm),
		.regValPc    (regValPc),
		.regValImm   (regValImm),
		.regInSp     (regInSp),
		.regInLr     (regInLr),
		.regInSr     (regInSr),
		.regInDlr    (regInDlr),
		.regInSchm   (regInSchm),
		.exHold      (exHold),	// Same cycle, not latched
		.nIdRn1      (nIdRn1),
		.nValRn1     (nValRn1),
		.nIdCn1      (nIdCn1),
		.nValCn1     (nValCn1),
		.nHeldIdRn1  (nHeldIdRn1),
		.nHeldIdCn1  (nHeldIdCn1),
		.nOutSp      (nOutSp),
		.nOutLr      (nOutLr),
		.nOutSr      (nOutSr),
		.nOutSchm    (nOutSchm),
		.nMemAddr    (nMemAddr),
		.nMemOpm     (nMemOpm),
		.nMemDataOut (nMemDataOut),
		.nTrapExc    (nTrapExc)
	);

	exStageLatch exStageLatch_i (
		.clock       (clock),
		.arstN       (arstN),
		.nIdRn1      (nIdRn1),
		.nValRn1     (nValRn1),
		.nIdCn1      (nIdCn1),
		.nValCn1     (nValCn1),
		.nHeldIdRn1  (nHeldIdRn1),
		.nHeldIdCn1  (nHeldIdCn1),
		.nOutSp      (nOutSp),
		.nOutLr      (nOutLr),
		.nOutSr      (nOutSr),
		.nOutSchm    (nOutSchm),
		.nMemAddr    (nMemAddr),
		.nMemOpm     (nMemOpm),
		.nMemDataOut (nMemDataOut),
		.nTrapExc    (nTrapExc),
		.regIdRn1    (regIdRn1),
		.regValRn1   (regValRn1),
		.regIdCn1    (regIdCn1),
		.regValCn1   (regValCn1),
		.heldIdRn1   (heldIdRn1),
		.heldIdCn1   (heldIdCn1),
		.regOutSp    (regOutSp),
		.regOutLr    (regOutLr),
		.regOutSr    (regOutSr),
		.regOutSchm  (regOutSchm),
		.memAddr     (memAddr),
		.memOpm      (memOpm),
		.memDataOut  (memDataOut),
		.exTrapExc   (exTrapExc)
	);

endmodule

/* verilog/exPkg.sv */
package exPkg;

	// Datapath widths
	localparam int dataW  = 64;
	localparam int addrW  = 32;
	localparam int gprIdW = 6;
	localparam int crIdW  = 5;
	localparam int immW   = 33;	// Bit 32 carries the sign
	localparam int ucW    = 6;
	localparam int opmW   = 5;
	localparam int schmW  = 8;
	localparam int trapW  = 16;

	localparam logic [dataW-1:0] spStep = 64'd8;	// One quadword per push or pop

	// Condition codes, top two bits of the command word
	localparam logic [1:0] ccAl = 2'b00;	// Always
	localparam logic [1:0] ccNv = 2'b01;	// Never
	localparam logic [1:0] ccCt = 2'b10;	// If SR.T set
	localparam logic [1:0] ccCf = 2'b11;	// If SR.T clear

	// Command codes
	localparam logic [ucW-1:0] ucNop    = 6'h00;
	localparam logic [ucW-1:0] ucInvop  = 6'h01;
	localparam logic [ucW-1:0] ucLeaMr  = 6'h02;
	localparam logic [ucW-1:0] ucMovRm  = 6'h03;	// Store
	localparam logic [ucW-1:0] ucMovMr  = 6'h04;	// Load
	localparam logic [ucW-1:0] ucPushx  = 6'h05;
	localparam logic [ucW-1:0] ucPopx   = 6'h06;
	localparam logic [ucW-1:0] ucMovRc  = 6'h07;
	localparam logic [ucW-1:0] ucMovCr  = 6'h08;
	localparam logic [ucW-1:0] ucMovIr  = 6'h09;
	localparam logic [ucW-1:0] ucBra    = 6'h0A;
	localparam logic [ucW-1:0] ucBraNb  = 6'h0B;	// Branch not taken
	localparam logic [ucW-1:0] ucBsr    = 6'h0C;
	localparam logic [ucW-1:0] ucJmp    = 6'h0D;
	localparam logic [ucW-1:0] ucJsr    = 6'h0E;
	localparam logic [ucW-1:0] ucOpIxt  = 6'h0F;

	// Sub-op codes under ucOpIxt
	localparam logic [5:0] ixNop   = 6'h00;
	localparam logic [5:0] ixSleep = 6'h01;
	localparam logic [5:0] ixBreak = 6'h02;
	localparam logic [5:0] ixClrt  = 6'h03;
	localparam logic [5:0] ixSett  = 6'h04;
	localparam logic [5:0] ixClrs  = 6'h05;
	localparam logic [5:0] ixSets  = 6'h06;
	localparam logic [5:0] ixNott  = 6'h07;
	localparam logic [5:0] ixNots  = 6'h08;
	localparam logic [5:0] ixRte   = 6'h09;
	localparam logic [5:0] ixTrapa = 6'h0A;
	localparam logic [5:0] ixSyse  = 6'h0B;

	// Memory ops: {dir[1:0], sign, size[1:0]}, dir 01 is load and 10 is store
	localparam logic [opmW-1:0] opmReady = 5'b00_0_00;
	localparam logic [opmW-1:0] opmRdQ   = 5'b01_0_11;
	localparam logic [opmW-1:0] opmWrQ   = 5'b10_0_11;

	// Register IDs
	localparam logic [gprIdW-1:0] grZzr = 6'h3F;	// Null GPR
	localparam logic [crIdW-1:0]  crZzr = 5'h1F;	// Null control register
	localparam logic [crIdW-1:0]  crPc  = 5'h00;
	localparam logic [crIdW-1:0]  grImm = 5'h1E;	// Implicit special register

	localparam int schmSp = 0;	// SP bit in the changed mask

	// Trap codes
	localparam logic [trapW-1:0] trapRte   = 16'hFF00;
	localparam logic [11:0]      trapaBase = 12'hC08;
	localparam logic [3:0]       syseBase  = 4'hE;

	// Extension word, read as a memory form or as a sub-op
	typedef union packed {
		struct packed {
			logic [1:0] resv;
			logic [1:0] size;	// Log2 of access bytes, also index scale
			logic       unused;
			logic       sign;
			logic [1:0] srcSel;
		} mem;
		struct packed {
			logic [1:0] resv;
			logic [5:0] subOp;
		} sub;
	} ixtWord_t;

endpackage

/* verilog/exPredicate.sv */
`timescale 1ns/1ps

module exPredicate (
	input  logic [7:0]              opUCmd,
	input  logic                    opBraFlush,
	input  logic                    srT,
	output logic [exPkg::ucW-1:0]   ucEff
);

	logic opEnable;

	// Condition code against SR.T
	always_comb begin
		case (opUCmd[7:6])
			exPkg::ccAl: opEnable = 1'b1;
			exPkg::ccNv: opEnable = 1'b0;
			exPkg::ccCt: opEnable = srT;
			exPkg::ccCf: opEnable = !srT;
			default:     opEnable = 1'b0;
		endcase
	end

	always_comb begin
		if (opBraFlush) begin
			ucEff = exPkg::ucNop;	// Flushed op does nothing at all
		end else if (opEnable) begin
			ucEff = opUCmd[5:0];
		end else if (opUCmd[5:0] == exPkg::ucBra) begin
			// Untaken branch may still need to undo a predicted redirect
			ucEff = exPkg::ucBraNb;
		end else begin
			ucEff = exPkg::ucNop;
		end
	end

endmodule

/* verilog/exStageLatch.sv */
`timescale 1ns/1ps

module exStageLatch (
	input  logic                     clock,
	input  logic                     arstN,
	input  logic [exPkg::gprIdW-1:0] nIdRn1,
	input  logic [exPkg::dataW-1:0]  nValRn1,
	input  logic [exPkg::crIdW-1:0]  nIdCn1,
	input  logic [exPkg::dataW-1:0]  nValCn1,
	input  logic [exPkg::gprIdW-1:0] nHeldIdRn1,
	input  logic [exPkg::crIdW-1:0]  nHeldIdCn1,
	input  logic [exPkg::dataW-1:0]  nOutSp,
	input  logic [exPkg::addrW-1:0]  nOutLr,
	input  logic [exPkg::dataW-1:0]  nOutSr,
	input  logic [exPkg::schmW-1:0]  nOutSchm,
	input  logic [exPkg::addrW-1:0]  nMemAddr,
	input  logic [exPkg::opmW-1:0]   nMemOpm,
	input  logic [exPkg::dataW-1:0]  nMemDataOut,
	input  logic [exPkg::trapW-1:0]  nTrapExc,
	output logic [exPkg::gprIdW-1:0] regIdRn1,
	output logic [exPkg::dataW-1:0]  regValRn1,
	output logic [exPkg::crIdW-1:0]  regIdCn1,
	output logic [exPkg::dataW-1:0]  regValCn1,
	output logic [exPkg::gprIdW-1:0] heldIdRn1,
	output logic [exPkg::crIdW-1:0]  heldIdCn1,
	output logic [exPkg::dataW-1:0]  regOutSp,
	output logic [exPkg::addrW-1:0]  regOutLr,
	output logic [exPkg::dataW-1:0]  regOutSr,
	output logic [exPkg::schmW-1:0]  regOutSchm,
	output logic [exPkg::addrW-1:0]  memAddr,
	output logic [exPkg::opmW-1:0]   memOpm,
	output logic [exPkg::dataW-1:0]  memDataOut,
	output logic [exPkg::trapW-1:0]  exTrapExc
);

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			regIdRn1   <= exPkg::grZzr;	// Null destinations
			regValRn1  <= '0;
			regIdCn1   <= exPkg::crZzr;
			regValCn1  <= '0;
			heldIdRn1  <= exPkg::grZzr;
			heldIdCn1  <= exPkg::crZzr;
			regOutSp   <= '0;
			regOutLr   <= '0;
			regOutSr   <= '0;
			regOutSchm <= '0;
			memAddr    <= '0;
			memOpm     <= exPkg::opmReady;	// No memory request
			memDataOut <= '0;
			exTrapExc  <= '0;
		end else begin
			regIdRn1   <= nIdRn1;
			regValRn1  <= nValRn1;
			regIdCn1   <= nIdCn1;
			regValCn1  <= nValCn1;
			heldIdRn1  <= nHeldIdRn1;
			heldIdCn1  <= nHeldIdCn1;
			regOutSp   <= nOutSp;
			regOutLr   <= nOutLr;
			regOutSr   <= nOutSr;
			regOutSchm <= nOutSchm;
			memAddr    <= nMemAddr;
			memOpm     <= nMemOpm;
			memDataOut <= nMemDataOut;
			exTrapExc  <= nTrapExc;
		end
	end

endmodule

/* verilog/exUcmdDecode.sv */
`timescale 1ns/1ps

module exUcmdDecode (
	input  logic [exPkg::ucW-1:0]    ucEff,
	input  exPkg::ixtWord_t          ixt,
	input  logic                     opPreBra,
	input  logic [exPkg::addrW-1:0]  aguAddr,
	input  logic [exPkg::gprIdW-1:0] regIdRm,
	input  logic [exPkg::dataW-1:0]  regValRs,
	input  logic [exPkg::dataW-1:0]  regValRm,
	input  logic [exPkg::dataW-1:0]  regValCRm,
	input  logic [exPkg::addrW-1:0]  regValPc,
	input  logic [exPkg::immW-1:0]   regValImm,
	input  logic [exPkg::dataW-1:0]  regInSp,
	input  logic [exPkg::addrW-1:0]  regInLr,
	input  logic [exPkg::dataW-1:0]  regInSr,
	input  logic [exPkg::dataW-1:0]  regInDlr,
	input  logic [exPkg::schmW-1:0]  regInSchm,
	output logic                     exHold,
	output logic [exPkg::gprIdW-1:0] nIdRn1,
	output logic [exPkg::dataW-1:0]  nValRn1,
	output logic [exPkg::crIdW-1:0]  nIdCn1,
	output logic [exPkg::dataW-1:0]  nValCn1,
	output logic [exPkg::gprIdW-1:0] nHeldIdRn1,
	output logic [exPkg::crIdW-1:0]  nHeldIdCn1,
	output logic [exPkg::dataW-1:0]  nOutSp,
	output logic [exPkg::addrW-1:0]  nOutLr,
	output logic [exPkg::dataW-1:0]  nOutSr,
	output logic [exPkg::schmW-1:0]  nOutSchm,
	output logic [exPkg::addrW-1:0]  nMemAddr,
	output logic [exPkg::opmW-1:0]   nMemOpm,
	output logic [exPkg::dataW-1:0]  nMemDataOut,
	output logic [exPkg::trapW-1:0]  nTrapExc
);

	logic [exPkg::dataW-1:0] spAdd8;
	logic [exPkg::dataW-1:0] spSub8;
	logic [exPkg::dataW-1:0] pcExt;
	logic [exPkg::dataW-1:0] aguExt;
	logic [exPkg::dataW-1:0] jmpExt;

	// SP steps touch bits 27..3 only, carry stops there
	assign spAdd8 = {regInSp[63:28], regInSp[27:3] + exPkg::spStep[27:3], regInSp[2:0]};
	assign spSub8 = {regInSp[63:28], regInSp[27:3] - exPkg::spStep[27:3], regInSp[2:0]};

	assign pcExt  = {{(exPkg::dataW-exPkg::addrW){1'b0}}, regValPc};
	assign aguExt = {{(exPkg::dataW-exPkg::addrW){1'b0}}, aguAddr};
	assign jmpExt = {{(exPkg::dataW-exPkg::addrW){1'b0}}, regValRs[exPkg::addrW-1:0]};

	always_comb begin
		nIdRn1      = exPkg::grZzr;
		nValRn1     = '0;
		nIdCn1      = exPkg::crZzr;
		nValCn1     = '0;
		nHeldIdRn1  = exPkg::grZzr;
		nHeldIdCn1  = exPkg::crZzr;
		nOutSp      = regInSp;
		nOutLr      = regInLr;
		nOutSr      = regInSr;
		nOutSchm    = regInSchm;
		nMemAddr    = aguAddr;
		nMemOpm     = exPkg::opmReady;
		nMemDataOut = regValRm;
		nTrapExc    = '0;
		exHold      = 1'b0;

		case (ucEff)
			exPkg::ucNop: begin
			end
			exPkg::ucLeaMr: begin
				nIdRn1  = regIdRm;
				nValRn1 = aguExt;
			end
			exPkg::ucMovRm: begin
				nMemOpm = {2'b10, ixt.mem.sign, ixt.mem.size};
			end
			exPkg::ucMovMr: begin
				nMemOpm    = {2'b01, ixt.mem.sign, ixt.mem.size};
				nHeldIdRn1 = regIdRm;	// Result arrives in a later stage
			end
			exPkg::ucPushx: begin
				nMemAddr   = spSub8[exPkg::addrW-1:0];	// Pre-decrement
				nOutSp     = spSub8;
				nMemOpm    = exPkg::opmWrQ;
				nHeldIdCn1 = exPkg::grImm;
				nOutSchm[exPkg::schmSp] = 1'b1;
				case (ixt.mem.srcSel)
					2'd0:    nMemDataOut = regValRs;
					2'd1:    nMemDataOut = regValCRm;
					2'd2:    nMemDataOut = '0;	// FPR source not present
					default: nMemDataOut = regValRs;
				endcase
			end
			exPkg::ucPopx: begin
				nMemAddr   = regInSp[exPkg::addrW-1:0];	// Post-increment
				nOutSp     = spAdd8;
				nMemOpm    = exPkg::opmRdQ;
				nHeldIdCn1 = exPkg::grImm;
				nOutSchm[exPkg::schmSp] = 1'b1;
			end
			exPkg::ucMovRc: begin
				nIdCn1  = regIdRm[exPkg::crIdW-1:0];
				nValCn1 = regValRs;
			end
			exPkg::ucMovCr: begin
				nIdRn1  = regIdRm;
				nValRn1 = regValCRm;
			end
			exPkg::ucMovIr: begin
				nIdRn1 = regIdRm;
				case (ixt.mem.srcSel)
					2'd0: begin
						nValRn1 = {{(exPkg::dataW-32){regValImm[exPkg::immW-1]}},
							regValImm[31:0]};
					end
					2'd1:    nValRn1 = {regValRs[55:0], regValImm[7:0]};
					2'd2:    nValRn1 = {regValRs[47:0], regValImm[15:0]};
					default: nValRn1 = {regValRs[31:0], regValImm[31:0]};
				endcase
			end
			exPkg::ucBraNb: begin
				// Fetch already went ahead, point PC back past the branch
				if (opPreBra) begin
					nIdCn1  = exPkg::crPc;
					nValCn1 = pcExt;
				end
			end
			exPkg::ucBra: begin
				if (!opPreBra) begin
					nIdCn1  = exPkg::crPc;
					nValCn1 = aguExt;
				end
			end
			exPkg::ucBsr: begin
				nOutLr = regValPc;
				if (!opPreBra) begin
					nIdCn1  = exPkg::crPc;
					nValCn1 = aguExt;
				end
			end
			exPkg::ucJmp: begin
				nIdCn1  = exPkg::crPc;
				nValCn1 = jmpExt;
			end
			exPkg::ucJsr: begin
				nOutLr  = regValPc;
				nIdCn1  = exPkg::crPc;
				nValCn1 = jmpExt;
			end
			exPkg::ucOpIxt: begin
				case (ixt.sub.subOp)
					exPkg::ixNop, exPkg::ixSleep: begin
					end
					exPkg::ixClrt: nOutSr[0] = 1'b0;
					exPkg::ixSett: nOutSr[0] = 1'b1;
					exPkg::ixNott: nOutSr[0] = !regInSr[0];
					exPkg::ixClrs: nOutSr[1] = 1'b0;
					exPkg::ixSets: nOutSr[1] = 1'b1;
					exPkg::ixNots: nOutSr[1] = !regInSr[1];
					exPkg::ixTrapa: nTrapExc = {exPkg::trapaBase, regIdRm[3:0]};
					exPkg::ixSyse:  nTrapExc = {exPkg::syseBase, regInDlr[11:0]};
					exPkg::ixRte:   nTrapExc = exPkg::trapRte;
					default: exHold = 1'b1;	// Break and unknown sub-ops
				endcase
			end
			default: exHold = 1'b1;	// ucInvop lands here too
		endcase
	end

endmodule
